// ==== pktbuf_pkg.sv ====
`default_nettype none

package pktbuf_pkg;

  // --------------------
  // buffer geometry
  localparam int DATA_W         = 32;               // packet word
  localparam int PAGE_COUNT     = 16;
  localparam int PAGE_W         = 4;                // page number
  localparam int LINES_PER_PAGE = 4;
  localparam int LINE_W         = 2;                // line within a page
  localparam int ADDR_W         = PAGE_W + LINE_W;  // {page, line}
  localparam int PREFETCH_DEPTH = 4;                // pages held or requested

  // counter widths derived from the sizes above
  localparam int PF_PTR_W = $clog2(PREFETCH_DEPTH);
  localparam int PF_CNT_W = $clog2(PREFETCH_DEPTH + 1);
  localparam int FL_CNT_W = $clog2(PAGE_COUNT + 1);

  // --------------------
  // state machines
  typedef enum logic [1:0] {
    s_idle, s_fill, s_link, s_desc
  } alloc_state_t;

  typedef enum logic [1:0] {
    r_idle, r_read, r_follow, r_free
  } reader_state_t;

  typedef enum logic {
    f_init, f_run
  } free_state_t;

endpackage

`default_nettype wire

// ==== page_free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_free_list (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          par_srdy,   // page request
  output logic                          par_drdy,
  output logic                          parr_srdy,  // page answer
  input  logic                          parr_drdy,
  output logic [pktbuf_pkg::PAGE_W-1:0] parr_page,
  input  logic                          ret_en,     // page back from the reader
  input  logic [pktbuf_pkg::PAGE_W-1:0] ret_page
);
  import pktbuf_pkg::*;

  free_state_t         state;
  logic [PAGE_W-1:0]   queue [PAGE_COUNT];
  logic [PAGE_W-1:0]   rd_ptr, wr_ptr;
  logic [PAGE_W-1:0]   init_page;
  logic [FL_CNT_W-1:0] count;  // free pages held
  logic [PF_CNT_W-1:0] pend;   // requests accepted, not yet answered
  logic                req, pop, push;
  logic [PAGE_W-1:0]   push_page;

  assign req       = par_srdy & par_drdy;
  assign pop       = parr_srdy & parr_drdy;
  assign push      = (state == f_init) | ret_en;
  assign push_page = (state == f_init) ? init_page : ret_page;

  assign par_drdy  = (pend < PF_CNT_W'(PREFETCH_DEPTH));
  assign parr_srdy = (state == f_run) & (pend != '0) & (count != '0);
  assign parr_page = queue[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      queue[wr_ptr] <= push_page;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= f_init;
      init_page <= '0;
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      count     <= '0;
      pend      <= '0;
    end
    else
    begin
      if (state == f_init)
      begin
        init_page <= init_page + PAGE_W'(1);
        if (init_page == PAGE_W'(PAGE_COUNT - 1))
          state <= f_run;  // all pages loaded
      end
      if (push)
        wr_ptr <= wr_ptr + PAGE_W'(1);  // wraps at PAGE_COUNT
      if (pop)
        rd_ptr <= rd_ptr + PAGE_W'(1);
      count <= count + FL_CNT_W'(push) - FL_CNT_W'(pop);
      pend  <= pend + PF_CNT_W'(req) - PF_CNT_W'(pop);
    end
  end

  // a returned page must have been handed out before, so there is room
  a_ret_room: assert property (@(posedge clk) disable iff (reset)
    ret_en |-> (count < FL_CNT_W'(PAGE_COUNT)));

endmodule

`default_nettype wire

// ==== page_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_allocator (
  input  logic                          clk,
  input  logic                          reset,
  // packet words from the accumulator
  input  logic                          in_srdy, in_eop, in_commit, in_abort,
  output logic                          in_drdy,
  input  logic [pktbuf_pkg::DATA_W-1:0] in_data,
  // free list
  output logic                          par_srdy, parr_drdy,
  input  logic                          par_drdy, parr_srdy,
  input  logic [pktbuf_pkg::PAGE_W-1:0] parr_page,
  // page memory writes
  output logic                          wr_en, wr_eop, lnk_en,
  output logic [pktbuf_pkg::ADDR_W-1:0] wr_addr,
  output logic [pktbuf_pkg::DATA_W-1:0] wr_data,
  output logic [pktbuf_pkg::PAGE_W-1:0] lnk_page, lnk_next,
  // descriptor to the reader
  output logic                          desc_srdy, desc_drop,
  input  logic                          desc_drdy,
  output logic [pktbuf_pkg::PAGE_W-1:0] desc_start, desc_end
);
  import pktbuf_pkg::*;

  alloc_state_t        state, nxt_state;
  logic [PAGE_W-1:0]   start_pg, nxt_start_pg;
  logic [PAGE_W-1:0]   cur_pg, nxt_cur_pg;
  logic [LINE_W-1:0]   cur_line, nxt_cur_line;
  logic                drop, nxt_drop;

  logic [PAGE_W-1:0]   pf_mem [PREFETCH_DEPTH];
  logic [PF_PTR_W-1:0] pf_rd, pf_wr;
  logic [PF_CNT_W-1:0] pf_cnt;                // pages sitting in the queue
  logic [PF_CNT_W-1:0] req_cnt, nxt_req_cnt;  // in flight plus held
  logic                pf_push, pf_take, pp_avail;
  logic [PAGE_W-1:0]   pp_page;

  // --------------------
  // page prefetch
  assign pp_avail    = (pf_cnt != '0);
  assign pp_page     = pf_mem[pf_rd];
  assign parr_drdy   = (pf_cnt < PF_CNT_W'(PREFETCH_DEPTH));
  assign pf_push     = parr_srdy & parr_drdy;
  assign nxt_req_cnt = req_cnt + PF_CNT_W'(par_srdy & par_drdy) - PF_CNT_W'(pf_take);

  always_ff @(posedge clk)
  begin
    if (pf_push)
      pf_mem[pf_wr] <= parr_page;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pf_rd    <= '0;
      pf_wr    <= '0;
      pf_cnt   <= '0;
      req_cnt  <= '0;
      par_srdy <= 1'b0;
    end
    else
    begin
      if (pf_push)
        pf_wr <= pf_wr + PF_PTR_W'(1);
      if (pf_take)
        pf_rd <= pf_rd + PF_PTR_W'(1);
      pf_cnt   <= pf_cnt + PF_CNT_W'(pf_push) - PF_CNT_W'(pf_take);
      req_cnt  <= nxt_req_cnt;
      par_srdy <= (nxt_req_cnt < PF_CNT_W'(PREFETCH_DEPTH));  // local credit limit
    end
  end

  // --------------------
  // packet FSM
  always_comb
  begin
    nxt_state    = state;
    nxt_start_pg = start_pg;
    nxt_cur_pg   = cur_pg;
    nxt_cur_line = cur_line;
    nxt_drop     = drop;
    pf_take      = 1'b0;
    in_drdy      = 1'b0;
    lnk_en       = 1'b0;
    desc_srdy    = 1'b0;
    case (state)
      s_idle:
      begin
        if (pp_avail)  // first page of the next packet
        begin
          pf_take      = 1'b1;
          nxt_start_pg = pp_page;
          nxt_cur_pg   = pp_page;
          nxt_cur_line = '0;
          nxt_state    = s_fill;
        end
      end
      s_fill:
      begin
        in_drdy = 1'b1;
        if (in_srdy)
        begin
          if (in_eop)
          begin
            nxt_drop  = in_abort | ~in_commit;  // missing commit counts as abort
            nxt_state = s_desc;
          end
          else if (cur_line == LINE_W'(LINES_PER_PAGE - 1))
            nxt_state = s_link;
          else
            nxt_cur_line = cur_line + LINE_W'(1);
        end
      end
      s_link:
      begin
        if (pp_avail)  // stall here until a page arrives
        begin
          lnk_en       = 1'b1;
          pf_take      = 1'b1;
          nxt_cur_pg   = pp_page;
          nxt_cur_line = '0;
          nxt_state    = s_fill;
        end
      end
      s_desc:
      begin
        desc_srdy = 1'b1;
        if (desc_drdy)
          nxt_state = s_idle;
      end
      default: nxt_state = s_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= s_idle;
      cur_line <= '0;
      drop     <= 1'b0;
    end
    else
    begin
      state    <= nxt_state;
      cur_line <= nxt_cur_line;
      drop     <= nxt_drop;
    end
  end

  always_ff @(posedge clk)
  begin
    start_pg <= nxt_start_pg;
    cur_pg   <= nxt_cur_pg;
  end

  assign wr_en      = in_srdy & in_drdy;
  assign wr_addr    = {cur_pg, cur_line};
  assign wr_data    = in_data;
  assign wr_eop     = in_eop;
  assign lnk_page   = cur_pg;   // link from the full page
  assign lnk_next   = pp_page;  // to the page about to be filled
  assign desc_start = start_pg;
  assign desc_end   = cur_pg;
  assign desc_drop  = drop;

  // a link leads to a fresh prefetched page, never back into the packet
  a_link_page: assert property (@(posedge clk) disable iff (reset)
    lnk_en |-> (lnk_next != lnk_page) && (lnk_next != start_pg));

endmodule

`default_nettype wire

// ==== page_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_memory (
  input  logic                          clk,
  // data lines
  input  logic                          wr_en, wr_eop,
  input  logic [pktbuf_pkg::ADDR_W-1:0] wr_addr,
  input  logic [pktbuf_pkg::DATA_W-1:0] wr_data,
  input  logic                          rd_en,
  input  logic [pktbuf_pkg::ADDR_W-1:0] rd_addr,
  output logic [pktbuf_pkg::DATA_W-1:0] rd_data,
  output logic                          rd_eop,
  // next-page links
  input  logic                          lnk_en,
  input  logic [pktbuf_pkg::PAGE_W-1:0] lnk_page, lnk_next,
  input  logic                          lrd_en,
  input  logic [pktbuf_pkg::PAGE_W-1:0] lrd_page,
  output logic [pktbuf_pkg::PAGE_W-1:0] lrd_next
);
  import pktbuf_pkg::*;

  logic [DATA_W-1:0] data_mem [PAGE_COUNT * LINES_PER_PAGE];
  logic              eop_mem  [PAGE_COUNT * LINES_PER_PAGE];
  logic [PAGE_W-1:0] link_mem [PAGE_COUNT];  // one entry per page

  // --------------------
  // data lines, registered read
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      data_mem[wr_addr] <= wr_data;
      eop_mem[wr_addr]  <= wr_eop;
    end
    if (rd_en)
    begin
      rd_data <= data_mem[rd_addr];
      rd_eop  <= eop_mem[rd_addr];
    end
  end

  // --------------------
  // links
  always_ff @(posedge clk)
  begin
    if (lnk_en)
      link_mem[lnk_page] <= lnk_next;
    if (lrd_en)
      lrd_next <= link_mem[lrd_page];
  end

endmodule

`default_nettype wire

// ==== packet_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module packet_reader (
  input  logic                          clk,
  input  logic                          reset,
  // descriptor from the allocator
  input  logic                          desc_srdy, desc_drop,
  output logic                          desc_drdy,
  input  logic [pktbuf_pkg::PAGE_W-1:0] desc_start, desc_end,
  // page memory reads
  output logic                          rd_en, lrd_en,
  output logic [pktbuf_pkg::ADDR_W-1:0] rd_addr,
  input  logic [pktbuf_pkg::DATA_W-1:0] rd_data,
  input  logic                          rd_eop,
  output logic [pktbuf_pkg::PAGE_W-1:0] lrd_page,
  input  logic [pktbuf_pkg::PAGE_W-1:0] lrd_next,
  // pages back to the free list
  output logic                          ret_en,
  output logic [pktbuf_pkg::PAGE_W-1:0] ret_page,
  // output stream
  output logic                          out_srdy, out_eop,
  input  logic                          out_drdy,
  output logic [pktbuf_pkg::DATA_W-1:0] out_data
);
  import pktbuf_pkg::*;

  reader_state_t     state, nxt_state;
  logic [PAGE_W-1:0] cur_pg, nxt_cur_pg;
  logic [PAGE_W-1:0] end_pg, nxt_end_pg;
  logic [LINE_W-1:0] line, nxt_line;
  logic              drop, nxt_drop;
  logic              last, nxt_last;  // current page ends the packet
  logic              rd_pend;         // one line read in flight
  logic              out_free;

  assign out_free = ~out_srdy | out_drdy;
  assign rd_addr  = {cur_pg, line};
  assign lrd_page = cur_pg;
  assign ret_page = cur_pg;

  always_comb
  begin
    nxt_state  = state;
    nxt_cur_pg = cur_pg;
    nxt_end_pg = end_pg;
    nxt_line   = line;
    nxt_drop   = drop;
    nxt_last   = last;
    desc_drdy  = 1'b0;
    rd_en      = 1'b0;
    lrd_en     = 1'b0;
    ret_en     = 1'b0;
    case (state)
      r_idle:
      begin
        desc_drdy = 1'b1;
        if (desc_srdy)
        begin
          nxt_cur_pg = desc_start;
          nxt_end_pg = desc_end;
          nxt_drop   = desc_drop;
          nxt_line   = '0;
          nxt_last   = desc_drop & (desc_start == desc_end);
          if (!desc_drop)
            nxt_state = r_read;
          else if (desc_start == desc_end)
            nxt_state = r_free;  // single-page drop
          else
            nxt_state = r_follow;
        end
      end
      r_read:
      begin
        if (rd_pend)  // line lands in the output register now
        begin
          if (rd_eop)
          begin
            nxt_last  = 1'b1;
            nxt_state = r_free;
          end
          else if (line == LINE_W'(LINES_PER_PAGE - 1))
            nxt_state = r_follow;
          else
            nxt_line = line + LINE_W'(1);
        end
        else if (out_free)
          rd_en = 1'b1;
      end
      r_follow:
      begin
        lrd_en    = 1'b1;
        nxt_state = r_free;
      end
      r_free:
      begin
        ret_en = 1'b1;
        if (last)
          nxt_state = r_idle;
        else
        begin
          nxt_cur_pg = lrd_next;
          nxt_line   = '0;
          if (!drop)
            nxt_state = r_read;
          else if (lrd_next == end_pg)
            nxt_last = 1'b1;  // stay and free the end page
          else
            nxt_state = r_follow;
        end
      end
      default: nxt_state = r_idle;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= r_idle;
      line     <= '0;
      drop     <= 1'b0;
      last     <= 1'b0;
      rd_pend  <= 1'b0;
      out_srdy <= 1'b0;
    end
    else
    begin
      state   <= nxt_state;
      line    <= nxt_line;
      drop    <= nxt_drop;
      last    <= nxt_last;
      rd_pend <= rd_en;
      if (rd_pend)
        out_srdy <= 1'b1;
      else if (out_drdy)
        out_srdy <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    cur_pg <= nxt_cur_pg;
    end_pg <= nxt_end_pg;
    if (rd_pend)
    begin
      out_data <= rd_data;
      out_eop  <= rd_eop;
    end
  end

  // back-pressure holds the word in place
  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    out_srdy && !out_drdy |=> out_srdy && $stable(out_data));

endmodule

`default_nettype wire

// ==== pktbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pktbuf_top (
  input  wire                          clk,
  input  wire                          reset,
  // packet input
  input  wire                          in_srdy,
  output wire                          in_drdy,
  input  wire [pktbuf_pkg::DATA_W-1:0] in_data,
  input  wire                          in_eop,
  input  wire                          in_commit,
  input  wire                          in_abort,
  // packet output
  output wire                          out_srdy,
  input  wire                          out_drdy,
  output wire [pktbuf_pkg::DATA_W-1:0] out_data,
  output wire                          out_eop
);
  import pktbuf_pkg::*;

  // --------------------
  // allocator and free list
  wire              par_srdy, par_drdy;
  wire              parr_srdy, parr_drdy;
  wire [PAGE_W-1:0] parr_page;
  wire              ret_en;
  wire [PAGE_W-1:0] ret_page;

  // memory ports
  wire              wr_en, wr_eop;
  wire [ADDR_W-1:0] wr_addr;
  wire [DATA_W-1:0] wr_data;
  wire              lnk_en;
  wire [PAGE_W-1:0] lnk_page, lnk_next;
  wire              rd_en, rd_eop;
  wire [ADDR_W-1:0] rd_addr;
  wire [DATA_W-1:0] rd_data;
  wire              lrd_en;
  wire [PAGE_W-1:0] lrd_page, lrd_next;

  // descriptors
  wire              desc_srdy, desc_drdy, desc_drop;
  wire [PAGE_W-1:0] desc_start, desc_end;

  page_free_list i_page_free_list (.*);
  page_allocator i_page_allocator (.*);
  page_memory    i_page_memory    (.*);
  packet_reader  i_packet_reader  (.*);

endmodule

`default_nettype wire

// ==== tb_pktbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pktbuf;
  import pktbuf_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYC  = 3;
  localparam int PASSES     = 5;    // 10 pages per pass, 50 in all, over 3 x PAGE_COUNT
  localparam int MARGIN     = 400;  // reset, free list fill and drain

  logic              clk;
  logic              reset;
  logic              in_srdy, in_drdy;
  logic [DATA_W-1:0] in_data;
  logic              in_eop, in_commit, in_abort;
  logic              out_srdy, out_drdy;
  logic [DATA_W-1:0] out_data;
  logic              out_eop;

  // pattern table, one entry per word
  logic [DATA_W-1:0] pat_data [$];
  bit                pat_eop [$];
  bit                pat_commit [$];
  bit                pat_abort [$];
  int                pat_gap [$];

  // words the output must carry, in order
  logic [DATA_W-1:0] exp_data [$];
  bit                exp_eop [$];

  int seed           = 32'h336a1d75;
  int cycle_cnt      = 0;
  int cycle_limit    = 0;

  pktbuf_top i_pktbuf_top (.*);

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------
  // pattern file
  task automatic load_patterns();
    int                fd;
    int                n;
    string             line;
    logic [DATA_W-1:0] d;
    int                e, c, a, g;
    fd = $fopen("pktbuf_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open pktbuf_patterns.txt");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd))
    begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line.getc(0) != "#")  // skip comments and blanks
      begin
        n = $sscanf(line, "%h %d %d %d %d", d, e, c, a, g);
        if (n != 5)
        begin
          $display("malformed line in pktbuf_patterns.txt: %s", line);
          $display("Simulation failed");
          $fatal(1);
        end
        pat_data.push_back(d);
        pat_eop.push_back(e != 0);
        pat_commit.push_back(c != 0);
        pat_abort.push_back(a != 0);
        pat_gap.push_back(g);
      end
    end
    $fclose(fd);
  endtask

  // each pass tags the top byte so repeated packets differ
  function automatic logic [DATA_W-1:0] pass_word(input int pass, input int idx);
    return pat_data[idx] ^ (DATA_W'(pass) << 24);
  endfunction

  // only committed packets reach the output
  task automatic build_expected();
    logic [DATA_W-1:0] pkt_data [$];
    bit                pkt_eop [$];
    for (int pass = 0; pass < PASSES; pass++)
    begin
      for (int idx = 0; idx < pat_data.size(); idx++)
      begin
        pkt_data.push_back(pass_word(pass, idx));
        pkt_eop.push_back(pat_eop[idx]);
        if (pat_eop[idx])
        begin
          if (pat_commit[idx])
          begin
            foreach (pkt_data[k])
            begin
              exp_data.push_back(pkt_data[k]);
              exp_eop.push_back(pkt_eop[k]);
            end
          end
          pkt_data.delete();
          pkt_eop.delete();
        end
      end
    end
  endtask

  // called on a rising edge, returns on the edge of the transfer
  task automatic send_word(input logic [DATA_W-1:0] d, input bit eop, input bit commit,
                           input bit abort, input int gap);
    if (gap > 0)
    begin
      in_srdy <= 1'b0;
      repeat (gap) @(posedge clk);
    end
    in_srdy   <= 1'b1;
    in_data   <= d;
    in_eop    <= eop;
    in_commit <= commit;
    in_abort  <= abort;
    @(posedge clk);
    while (!in_drdy)
      @(posedge clk);
  endtask

  // --------------------
  // stimulus and end of run
  initial
  begin
    reset     = 1'b1;
    in_srdy   = 1'b0;
    in_data   = '0;
    in_eop    = 1'b0;
    in_commit = 1'b0;
    in_abort  = 1'b0;
    out_drdy  = 1'b0;
    load_patterns();
    build_expected();
    cycle_limit = 20 * PASSES * pat_data.size() + MARGIN;
    repeat (RESET_CYC) @(posedge clk);
    reset <= 1'b0;
    for (int pass = 0; pass < PASSES; pass++)
      for (int idx = 0; idx < pat_data.size(); idx++)
        send_word(pass_word(pass, idx), pat_eop[idx], pat_commit[idx],
                  pat_abort[idx], pat_gap[idx]);
    in_srdy <= 1'b0;
    in_eop  <= 1'b0;
    while (exp_data.size() != 0)
      @(posedge clk);
    repeat (40) @(posedge clk);  // room for any stray word
    $display("Simulation completed successfully");
    $finish;
  end

  // --------------------
  // output checker with random back-pressure
  always @(posedge clk)
  begin
    if (!reset)
    begin
      out_drdy <= (($random(seed) & 32'h3) != 0);
      if (out_srdy && out_drdy)
      begin
        assert (exp_data.size() > 0)
        else
        begin
          $display("output word %h arrived when no word was expected", out_data);
          $display("Simulation failed");
          $fatal(1);
        end
        assert (out_data == exp_data[0])
        else
        begin
          $display("[FAIL] t=%0t out_data expected %h actual %h", $time, exp_data[0], out_data);
          $display("Simulation failed");
          $fatal(1);
        end
        assert (out_eop == exp_eop[0])
        else
        begin
          $display("[FAIL] t=%0t out_eop expected %0b actual %0b", $time, exp_eop[0], out_eop);
          $display("Simulation failed");
          $fatal(1);
        end
        void'(exp_data.pop_front());
        void'(exp_eop.pop_front());
      end
    end
  end

  // run limit
  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit)
    begin
      $display("timeout after %0d cycles with %0d words still expected",
               cycle_cnt, exp_data.size());
      $display("Simulation failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== pktbuf_patterns.txt ====
# data(hex) eop commit abort gap
# gap is the number of idle cycles before the word
a0000001 1 1 0 0
b0000001 0 0 0 2
b0000002 0 0 0 0
b0000003 1 0 1 1
c0000001 0 0 0 0
c0000002 0 0 0 0
c0000003 0 0 0 3
c0000004 1 1 0 0
d0000001 0 0 0 1
d0000002 0 0 0 0
d0000003 0 0 0 0
d0000004 0 0 0 2
d0000005 1 1 0 0
e0000001 0 0 0 0
e0000002 0 0 0 1
e0000003 0 0 0 0
e0000004 0 0 0 0
e0000005 0 0 0 0
e0000006 1 0 1 2
f0000001 0 0 0 0
f0000002 0 0 0 0
f0000003 0 0 0 1
f0000004 0 0 0 0
f0000005 0 0 0 0
f0000006 0 0 0 3
f0000007 0 0 0 0
f0000008 0 0 0 0
f0000009 1 1 0 0

// ==== src.f ====
pktbuf_pkg.sv
page_free_list.sv
page_allocator.sv
page_memory.sv
packet_reader.sv
pktbuf_top.sv
tb_pktbuf.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the packet buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_TEXT="Simulation completed successfully"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_pktbuf -f src.f -o tb_pktbuf_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_pktbuf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$PASS_TEXT" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
